/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_udp_tx
FILELIST  = files.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)

/* bench/tb_udp_tx.sv */
// Self-checking testbench for the UDP transmitter, runs the frames listed in the input data file
`timescale 1ns/1ps

module tb_udp_tx;

    localparam logic [47:0] BOARD_MAC  = 48'h00_11_22_33_44_55;
    localparam logic [31:0] BOARD_IP   = 32'hc0a8017b;  // 192.168.1.123
    localparam logic [15:0] UDP_PORT   = 16'd1234;
    localparam int          MAX_WAIT   = 4000;          // Cycles allowed per wait loop
    localparam int          BUSY_BYTE  = 60;            // Payload byte that gets a second strobe

    logic        clk;
    logic        rst_n;
    logic        tx_start_en;
    logic [15:0] tx_byte_num;
    logic [47:0] des_mac;
    logic [31:0] des_ip;
    logic [31:0] tx_data;
    logic        tx_req;
    logic        tx_done;
    logic        gmii_tx_en;
    logic [7:0]  gmii_txd;

    // Frame table from the data file
    int          len_q[$];
    logic [47:0] mac_q[$];
    logic [31:0] ip_q[$];
    logic [31:0] word_q[$];
    logic [15:0] cksum_q[$];

    logic [7:0]  exp_q[$];
    logic [7:0]  got_q[$];
    logic [31:0] first_word;
    int          word_idx;   // Words served in the current frame
    int          done_cnt;
    int          frames;
    int          errors;
    int          timeouts;
    integer      seed;

    udp_tx_top #(
        .BOARD_MAC (BOARD_MAC),
        .BOARD_IP  (BOARD_IP),
        .UDP_PORT  (UDP_PORT)
    ) u_udp_tx_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .tx_start_en (tx_start_en),
        .tx_byte_num (tx_byte_num),
        .des_mac     (des_mac),
        .des_ip      (des_ip),
        .tx_data     (tx_data),
        .tx_req      (tx_req),
        .tx_done     (tx_done),
        .gmii_tx_en  (gmii_tx_en),
        .gmii_txd    (gmii_txd)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // --------------------------------------------------
    // Cycle step and payload source
    // --------------------------------------------------
    task automatic tick();
        @(negedge clk);
        if (tx_req) begin  // Next word goes out right after the request
            tx_data  = first_word + 32'(word_idx);
            word_idx = word_idx + 1;
        end
        if (tx_done) done_cnt = done_cnt + 1;
    endtask

    task automatic read_frames();
        int          fd;
        int          n;
        string       line;
        int          plen;
        logic [47:0] mac;
        logic [31:0] ip;
        logic [31:0] word;
        logic [15:0] ck;
        fd = $fopen("bench/udp_tx_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open bench/udp_tx_input.txt");
            errors = errors + 1;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 1 && line[0] != "#") begin
                    if ($sscanf(line, "%d %h %h %h %h", plen, mac, ip, word, ck) == 5) begin
                        len_q.push_back(plen);
                        mac_q.push_back(mac);
                        ip_q.push_back(ip);
                        word_q.push_back(word);
                        cksum_q.push_back(ck);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // --------------------------------------------------
    // Expected frame
    // --------------------------------------------------
    task automatic push_field(input logic [63:0] value, input int nbytes);
        int k;
        for (k = nbytes - 1; k >= 0; k--) exp_q.push_back(value[8*k +: 8]);  // Network order
    endtask

    // Ethernet CRC-32, MSB-first shift register fed with each byte LSB first
    function automatic logic [31:0] frame_crc(input int first);
        logic [31:0] crc;
        logic [31:0] refl;
        logic [7:0]  d;
        logic        fb;
        int          k;
        int          b;
        crc = 32'hffffffff;
        for (k = first; k < exp_q.size(); k++) begin
            d = exp_q[k];
            for (b = 0; b < 8; b++) begin
                fb  = d[b] ^ crc[31];
                crc = {crc[30:0], 1'b0};
                if (fb) crc = crc ^ 32'h04c11db7;
            end
        end
        for (b = 0; b < 32; b++) refl[b] = crc[31 - b];
        return ~refl;
    endfunction

    task automatic build_expected(input int idx, input logic [15:0] ident);
        int          plen;
        int          k;
        logic [31:0] w;
        logic [31:0] fcs;
        plen = len_q[idx];
        exp_q.delete();
        for (k = 0; k < 7; k++) exp_q.push_back(8'h55);
        exp_q.push_back(8'hd5);
        push_field(64'(mac_q[idx]), 6);
        push_field(64'(BOARD_MAC), 6);
        push_field(64'h0800, 2);
        push_field(64'h4500, 2);
        push_field(64'(plen + 28), 2);  // IPv4 total length
        push_field(64'(ident), 2);
        push_field(64'h4000, 2);
        push_field(64'h4011, 2);        // TTL 64, protocol UDP
        push_field(64'(cksum_q[idx]), 2);
        push_field(64'(BOARD_IP), 4);
        push_field(64'(ip_q[idx]), 4);
        push_field(64'(UDP_PORT), 2);
        push_field(64'(UDP_PORT), 2);
        push_field(64'(plen + 8), 2);   // UDP length
        push_field(64'h0, 2);
        for (k = 0; k < plen || k < 18; k++) begin
            w = word_q[idx] + 32'(k / 4);
            exp_q.push_back((k < plen) ? w[8*(3 - k % 4) +: 8] : 8'h00);
        end
        fcs = frame_crc(8);
        for (k = 0; k < 4; k++) exp_q.push_back(fcs[8*k +: 8]);  // Low byte first
    endtask

    task automatic check_idle_outputs();
        if (tx_req !== 1'b0) begin
            $display("[FAIL] tx_req idle: got %h expected %h", tx_req, 1'b0);
            errors = errors + 1;
        end
        if (tx_done !== 1'b0) begin
            $display("[FAIL] tx_done idle: got %h expected %h", tx_done, 1'b0);
            errors = errors + 1;
        end
        if (gmii_tx_en !== 1'b0 || gmii_txd !== 8'h00) begin
            $display("[FAIL] gmii_tx_en/gmii_txd idle: got %h/%h expected 0/00",
                     gmii_tx_en, gmii_txd);
            errors = errors + 1;
        end
    endtask

    // --------------------------------------------------
    // One frame from strobe to tx_done
    // --------------------------------------------------
    task automatic run_frame(input int idx);
        int lat;
        int cnt;
        int k;
        int exp_len;
        int exp_req;
        frames = frames + 1;
        build_expected(idx, 16'(frames));
        exp_len    = 8 + 14 + 28 + ((len_q[idx] < 18) ? 18 : len_q[idx]) + 4;
        exp_req    = (len_q[idx] + 3) / 4;
        first_word = word_q[idx];
        word_idx   = 0;
        got_q.delete();
        tx_start_en = 1'b1;
        tx_byte_num = 16'(len_q[idx]);
        des_mac     = mac_q[idx];
        des_ip      = ip_q[idx];
        tick();
        tx_start_en = 1'b0;
        des_mac     = ~des_mac;  // Header must come from the snapshot
        des_ip      = ~des_ip;
        tx_byte_num = 16'hffff;
        lat = 0;
        while (!gmii_tx_en && lat < MAX_WAIT) begin
            tick();
            lat = lat + 1;
        end
        if (!gmii_tx_en) begin
            $display("Timed out waiting for gmii_tx_en after the start strobe of frame %0d",
                     frames);
            timeouts = timeouts + 1;
            return;
        end
        if (lat != 7) begin
            $display("[FAIL] gmii_tx_en latency: got %h expected %h", lat, 7);
            errors = errors + 1;
        end
        cnt = 0;
        while (gmii_tx_en && cnt < MAX_WAIT) begin
            got_q.push_back(gmii_txd);
            tx_start_en = (cnt == BUSY_BYTE);  // Strobe while busy
            tick();
            cnt = cnt + 1;
        end
        tx_start_en = 1'b0;
        if (gmii_tx_en) begin
            $display("Timed out waiting for the end of frame %0d", frames);
            timeouts = timeouts + 1;
            return;
        end
        if (tx_done !== 1'b1 || done_cnt != frames) begin
            $display("[FAIL] tx_done at frame end: got %h (count %h) expected 1 (count %h)",
                     tx_done, done_cnt, frames);
            errors = errors + 1;
        end
        if (word_idx != exp_req) begin
            $display("[FAIL] tx_req count: got %h expected %h", word_idx, exp_req);
            errors = errors + 1;
        end
        if (got_q.size() != exp_len) begin
            $display("[FAIL] gmii_tx_en byte count: got %h expected %h", got_q.size(), exp_len);
            errors = errors + 1;
        end
        for (k = 0; k < got_q.size() && k < exp_q.size(); k++) begin
            if (got_q[k] !== exp_q[k]) begin
                $display("[FAIL] gmii_txd frame %0d byte %0d: got %h expected %h",
                         frames, k, got_q[k], exp_q[k]);
                errors = errors + 1;
            end
        end
    endtask

    initial begin
        int i;
        int k;
        int gap;
        tx_start_en = 1'b0;
        tx_byte_num = '0;
        des_mac     = '0;
        des_ip      = '0;
        tx_data     = '0;
        rst_n       = 1'b0;
        first_word  = '0;
        word_idx    = 0;
        done_cnt    = 0;
        frames      = 0;
        errors      = 0;
        timeouts    = 0;
        seed        = 32'h3376fe1d;
        read_frames();
        if (len_q.size() == 0 && errors == 0) begin
            $display("No frames found in the input data file");
            errors = errors + 1;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        check_idle_outputs();
        rst_n = 1'b1;
        tick();
        tick();
        check_idle_outputs();

        for (i = 0; i < len_q.size() && timeouts == 0; i++) begin
            run_frame(i);
            gap = $unsigned($random(seed)) % 16;
            for (k = 0; k < gap; k++) begin
                tick();
                if (gmii_tx_en) begin
                    $display("gmii_tx_en went high between frames without a start strobe");
                    errors = errors + 1;
                end
            end
        end

        // A late strobe would show up here as a rogue frame
        for (k = 0; k < 40; k++) begin
            tick();
            if (gmii_tx_en) begin
                $display("gmii_tx_en went high after the last frame");
                errors = errors + 1;
            end
        end
        if (done_cnt != frames) begin
            $display("[FAIL] tx_done total: got %h expected %h", done_cnt, frames);
            errors = errors + 1;
        end

        $display("Frames %0d, errors %0d, timeouts %0d", frames, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* bench/udp_tx_input.txt */
# length(dec) dest_mac(hex) dest_ip(hex) first_payload_word(hex) ip_checksum(hex)
# Checksums use source IP c0a8017b and identification 1, 2, 3 ... in line order
1  020000000001 c0a80102 a1b2c3d4 b701
4  020000000002 c0a80103 00010203 b6fc
17 0a1b2c3d4e5f 0a000001 11223344 6e99
18 ffffffffffff ffffffff deadbeef 7898
19 3c970e123456 ac100a05 cafe0000 c280
64 001a2b3c4d5e 08080808 00000000 6858
5  020000000007 c0a801fe 80808080 b5fb
46 5e0001020304 e0000001 01234567 9876

/* files.f */
source/udp_tx_pkg.sv
source/frame_if.sv
source/udp_tx_ctrl.sv
source/ip_header_gen.sv
source/eth_crc32.sv
source/gmii_byte_mux.sv
source/udp_tx_top.sv
bench/tb_udp_tx.sv

/* source/eth_crc32.sv */
// Byte-wise Ethernet CRC-32 over the transmitted frame, supplies the four FCS bytes
`timescale 1ns/1ps

module eth_crc32
    import udp_tx_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  byte_t txd,        // Registered GMII byte
    output byte_t fcs_byte,
    frame_if.crc  fr
);

    localparam logic [31:0] POLY_REFL = 32'hEDB88320;  // 04C11DB7 reflected

    logic [31:0] crc_q;
    logic [31:0] crc_next;
    logic [31:0] crc_out;
    logic        crc_en_q;   // crc_en lined up with the byte now on txd

    // LSB first, matching GMII bit order
    function automatic logic [31:0] crc_byte(input logic [31:0] crc, input byte_t data);
        logic [31:0] c;
        int          i;
        c = crc ^ {24'h0, data};
        for (i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ POLY_REFL) : (c >> 1);
        end
        return c;
    endfunction

    assign crc_next = crc_byte(crc_q, txd);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crc_en_q <= 1'b0;
            crc_q    <= '1;
        end else begin
            crc_en_q <= fr.crc_en;
            if (fr.crc_clr)
                crc_q <= '1;
            else if (crc_en_q)
                crc_q <= crc_next;
        end
    end

    // First FCS cycle still has the last payload byte in flight
    assign crc_out = crc_en_q ? crc_next : crc_q;

    // Complemented remainder, low byte first on the wire
    assign fcs_byte = (fr.phase == PH_FCS) ? ~crc_out[{fr.lane, 3'b000} +: 8] : '0;

    // Preamble starts from a cleared remainder with nothing fed in
    a_no_crc_in_preamble: assert property (@(posedge clk) disable iff (!rst_n)
        (fr.phase == PH_PREAMBLE) |-> (!crc_en_q && crc_q == '1));

endmodule

/* source/frame_if.sv */
// Frame sequencing bundle from the transmit FSM to the header, byte mux and CRC blocks
`timescale 1ns/1ps

interface frame_if
    import udp_tx_pkg::*;
();

    tx_phase_e  phase;
    logic [4:0] byte_idx;  // Position inside preamble or header phases
    logic [1:0] lane;      // Byte of the current word, payload and FCS
    logic       pad;       // Zero fill after the real payload
    logic       crc_en;
    logic       crc_clr;
    logic       hdr_load;  // Starts header snapshot and checksum
    logic       sum_done;  // Checksum stored, header ready

    modport ctrl (
        output phase, byte_idx, lane, pad, crc_en, crc_clr, hdr_load,
        input  sum_done
    );

    modport hdr (input phase, byte_idx, hdr_load, output sum_done);

    modport mux (input phase, byte_idx, lane, pad);

    modport crc (input phase, lane, crc_en, crc_clr);

endinterface

/* source/gmii_byte_mux.sv */
// Picks the frame byte for the current phase and drives the registered GMII transmit pins
`timescale 1ns/1ps

module gmii_byte_mux
    import udp_tx_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  word_t tx_data,
    input  byte_t hdr_byte,
    input  byte_t fcs_byte,
    output logic  gmii_tx_en,
    output byte_t gmii_txd,
    frame_if.mux  fr
);

    localparam logic [4:0] SFD_IDX  = 5'(PREAMBLE_BYTES - 1);
    localparam logic [4:0] HDR_LAST = 5'(IP_HDR_BYTES + UDP_HDR_BYTES - 1);

    word_t data_word;
    byte_t tx_byte;
    logic  tx_active;
    logic  word_load;

    // Source updates tx_data the cycle before a word's first byte
    assign word_load = (fr.phase == PH_IP_HEAD && fr.byte_idx == HDR_LAST)
                    || (fr.phase == PH_PAYLOAD && fr.lane == 2'd3);

    always_ff @(posedge clk) begin
        if (word_load) data_word <= tx_data;
    end

    // --------------------------------------------------
    // Byte select
    // --------------------------------------------------
    always_comb begin
        case (fr.phase)
            PH_PREAMBLE: tx_byte = (fr.byte_idx == SFD_IDX) ? SFD_BYTE : PREAMBLE_BYTE;
            PH_ETH_HEAD,
            PH_IP_HEAD:  tx_byte = hdr_byte;
            // Lane 0 takes the top byte, ~lane gives 3 - lane
            PH_PAYLOAD:  tx_byte = fr.pad ? '0 : data_word[{~fr.lane, 3'b000} +: 8];
            PH_FCS:      tx_byte = fcs_byte;
            default:     tx_byte = '0;
        endcase
    end

    assign tx_active = fr.phase inside {PH_PREAMBLE, PH_ETH_HEAD, PH_IP_HEAD,
                                        PH_PAYLOAD, PH_FCS};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gmii_tx_en <= 1'b0;
            gmii_txd   <= '0;
        end else begin
            gmii_tx_en <= tx_active;
            gmii_txd   <= tx_byte;  // Zero between frames
        end
    end

endmodule

/* source/ip_header_gen.sv */
// Builds the Ethernet, IPv4 and UDP headers for one frame and computes the IPv4 checksum
`timescale 1ns/1ps

module ip_header_gen
    import udp_tx_pkg::*;
#(
    parameter mac_t        BOARD_MAC = 48'h00_11_22_33_44_55,
    parameter ip_addr_t    BOARD_IP  = {8'd192, 8'd168, 8'd1, 8'd123},
    parameter logic [15:0] UDP_PORT  = 16'd1234
)(
    input  logic     clk,
    input  logic     rst_n,
    input  mac_t     des_mac,
    input  ip_addr_t des_ip,
    input  len_t     tx_byte_num,
    output byte_t    hdr_byte,
    frame_if.hdr     fr
);

    localparam logic [15:0] VER_IHL_TOS = 16'h4500;  // IPv4, 5 words, TOS 0

    mac_t        dst_mac;
    ip_addr_t    dst_ip;
    len_t        pay_len;
    len_t        total_len;
    len_t        udp_len;
    logic [15:0] ident;
    logic [3:0]  stage;     // Checksum pipeline position
    logic [31:0] sum_acc;
    logic [15:0] ip_cksum;
    logic        sum_done;

    byte_t [0:ETH_HDR_BYTES-1]                 eth_hdr;
    byte_t [0:IP_HDR_BYTES+UDP_HDR_BYTES-1]    ip_udp_hdr;

    // --------------------------------------------------
    // Snapshot and checksum datapath
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        // Last idle sample is the strobe cycle, then held for the frame
        if (fr.phase == PH_IDLE) begin
            dst_mac <= des_mac;
            dst_ip  <= des_ip;
            pay_len <= tx_byte_num;
        end
        if (fr.hdr_load) begin
            total_len <= pay_len + 16'(IP_HDR_BYTES + UDP_HDR_BYTES);
            udp_len   <= pay_len + 16'(UDP_HDR_BYTES);
        end
        // Ten header words, checksum field counted as zero
        if (stage[0]) begin
            sum_acc <= 32'(VER_IHL_TOS) + 32'(total_len) + 32'(ident) + 32'(IP_FLAGS_DF)
                     + 32'({IP_TTL, IP_PROTO_UDP})
                     + 32'(BOARD_IP[31:16]) + 32'(BOARD_IP[15:0])
                     + 32'(dst_ip[31:16]) + 32'(dst_ip[15:0]);
        end else if (stage[1] || stage[2]) begin
            sum_acc <= {16'h0, sum_acc[31:16]} + {16'h0, sum_acc[15:0]};  // Fold carry
        end
        if (stage[3]) ip_cksum <= ~sum_acc[15:0];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ident    <= '0;
            stage    <= '0;
            sum_done <= 1'b0;
        end else begin
            if (fr.hdr_load) ident <= ident + 16'd1;  // First frame goes out with 1
            stage    <= {stage[2:0], fr.hdr_load};
            sum_done <= stage[3];
        end
    end

    assign fr.sum_done = sum_done;

    // --------------------------------------------------
    // Header byte select
    // --------------------------------------------------
    assign eth_hdr    = {dst_mac, BOARD_MAC, ETH_TYPE_IPV4};
    assign ip_udp_hdr = {VER_IHL_TOS, total_len, ident, IP_FLAGS_DF,
                         IP_TTL, IP_PROTO_UDP, ip_cksum, BOARD_IP, dst_ip,
                         UDP_PORT, UDP_PORT, udp_len, 16'h0000};  // UDP checksum unused

    always_comb begin
        case (fr.phase)
            PH_ETH_HEAD: hdr_byte = eth_hdr[fr.byte_idx[3:0]];
            PH_IP_HEAD:  hdr_byte = ip_udp_hdr[fr.byte_idx];
            default:     hdr_byte = '0;
        endcase
    end

    // Checksum lands while the FSM still waits for it
    a_sum_in_checksum: assert property (@(posedge clk) disable iff (!rst_n)
        fr.sum_done |-> (fr.phase == PH_CHECKSUM));

endmodule

/* source/udp_tx_ctrl.sv */
// Transmit FSM, steps a frame through its phases and paces payload word requests
`timescale 1ns/1ps

module udp_tx_ctrl
    import udp_tx_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  tx_start_en,
    input  len_t  tx_byte_num,
    output logic  tx_req,
    output logic  tx_done,
    frame_if.ctrl fr
);

    localparam logic [4:0] PRE_LAST = 5'(PREAMBLE_BYTES - 1);
    localparam logic [4:0] ETH_LAST = 5'(ETH_HDR_BYTES - 1);
    localparam logic [4:0] HDR_LAST = 5'(IP_HDR_BYTES + UDP_HDR_BYTES - 1);
    localparam logic [4:0] REQ_IDX  = HDR_LAST - 5'd2;  // First word asked for here

    tx_phase_e  phase;
    logic [4:0] byte_idx;
    logic [1:0] lane;
    len_t       data_len;   // Real payload bytes
    len_t       frame_len;  // Payload after padding to the minimum
    len_t       pay_cnt;
    logic       hdr_load;
    logic       fcs_last;
    logic       more_words;

    // Another word exists past the one whose lane 1 is going out now
    assign more_words = ({1'b0, pay_cnt} + 17'd3) < {1'b0, data_len};

    // Lengths are sampled with the strobe
    always_ff @(posedge clk) begin
        if (phase == PH_IDLE && tx_start_en) begin
            data_len  <= tx_byte_num;
            frame_len <= (tx_byte_num < len_t'(MIN_PAYLOAD_BYTES)) ?
                         len_t'(MIN_PAYLOAD_BYTES) : tx_byte_num;
        end
    end

    // --------------------------------------------------
    // Phase sequencing
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase    <= PH_IDLE;
            byte_idx <= '0;
            lane     <= '0;
            pay_cnt  <= '0;
            hdr_load <= 1'b0;
            tx_req   <= 1'b0;
            fcs_last <= 1'b0;
            tx_done  <= 1'b0;
        end else begin
            hdr_load <= 1'b0;
            tx_req   <= 1'b0;
            fcs_last <= 1'b0;
            tx_done  <= fcs_last;  // One cycle after the last FCS byte leaves
            case (phase)
                PH_IDLE: begin
                    if (tx_start_en) begin  // Strobes in any other phase are dropped
                        phase    <= PH_CHECKSUM;
                        hdr_load <= 1'b1;
                    end
                end
                PH_CHECKSUM: begin
                    if (fr.sum_done) phase <= PH_PREAMBLE;
                end
                PH_PREAMBLE: begin
                    if (byte_idx == PRE_LAST) begin
                        phase    <= PH_ETH_HEAD;
                        byte_idx <= '0;
                    end else begin
                        byte_idx <= byte_idx + 5'd1;
                    end
                end
                PH_ETH_HEAD: begin
                    if (byte_idx == ETH_LAST) begin
                        phase    <= PH_IP_HEAD;
                        byte_idx <= '0;
                    end else begin
                        byte_idx <= byte_idx + 5'd1;
                    end
                end
                PH_IP_HEAD: begin
                    if (byte_idx == REQ_IDX) tx_req <= 1'b1;
                    if (byte_idx == HDR_LAST) begin
                        phase    <= PH_PAYLOAD;
                        byte_idx <= '0;
                        pay_cnt  <= '0;
                        lane     <= '0;
                    end else begin
                        byte_idx <= byte_idx + 5'd1;
                    end
                end
                PH_PAYLOAD: begin
                    lane <= lane + 2'd1;
                    // Request lands two cycles before the word's first byte
                    if (lane == 2'd1 && more_words) tx_req <= 1'b1;
                    if (pay_cnt == frame_len - 16'd1) begin
                        phase   <= PH_FCS;
                        pay_cnt <= '0;
                        lane    <= '0;
                    end else begin
                        pay_cnt <= pay_cnt + 16'd1;
                    end
                end
                PH_FCS: begin
                    lane <= lane + 2'd1;
                    if (lane == 2'd3) begin
                        phase    <= PH_IDLE;
                        fcs_last <= 1'b1;
                    end
                end
                default: phase <= PH_IDLE;
            endcase
        end
    end

    assign fr.phase    = phase;
    assign fr.byte_idx = byte_idx;
    assign fr.lane     = lane;
    assign fr.hdr_load = hdr_load;
    assign fr.pad      = (phase == PH_PAYLOAD) && (pay_cnt >= data_len);
    assign fr.crc_en   = phase inside {PH_ETH_HEAD, PH_IP_HEAD, PH_PAYLOAD};
    assign fr.crc_clr  = tx_done;  // Remainder back to all ones between frames

    // An accepted frame must carry payload
    a_len_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        (phase == PH_IDLE && tx_start_en) |-> (tx_byte_num != '0));

    a_req_phase: assert property (@(posedge clk) disable iff (!rst_n)
        tx_req |-> (phase inside {PH_IP_HEAD, PH_PAYLOAD}));

endmodule

/* source/udp_tx_pkg.sv */
// Shared types, protocol constants and the frame phase encoding for the UDP transmitter RTL
package udp_tx_pkg;

    // --------------------------------------------------
    // Data types
    // --------------------------------------------------
    typedef logic [7:0]  byte_t;     // One GMII byte
    typedef logic [31:0] word_t;     // One payload word
    typedef logic [15:0] len_t;      // Byte count
    typedef logic [47:0] mac_t;
    typedef logic [31:0] ip_addr_t;

    // Frame phases in transmit order
    typedef enum logic [2:0] {
        PH_IDLE,
        PH_CHECKSUM,
        PH_PREAMBLE,
        PH_ETH_HEAD,
        PH_IP_HEAD,
        PH_PAYLOAD,
        PH_FCS
    } tx_phase_e;

    // --------------------------------------------------
    // Ethernet framing
    // --------------------------------------------------
    localparam byte_t       PREAMBLE_BYTE  = 8'h55;
    localparam byte_t       SFD_BYTE       = 8'hd5;
    localparam logic [15:0] ETH_TYPE_IPV4  = 16'h0800;
    localparam int          PREAMBLE_BYTES = 8;    // Seven preamble bytes plus SFD
    localparam int          ETH_HDR_BYTES  = 14;

    // --------------------------------------------------
    // IPv4 and UDP
    // --------------------------------------------------
    localparam int          IP_HDR_BYTES      = 20;
    localparam int          UDP_HDR_BYTES     = 8;
    localparam int          MIN_PAYLOAD_BYTES = 18;  // 46 byte minimum minus both headers
    localparam byte_t       IP_PROTO_UDP      = 8'd17;
    localparam byte_t       IP_TTL            = 8'h40;
    localparam logic [15:0] IP_FLAGS_DF       = 16'h4000;  // Don't fragment, offset 0

endpackage

/* source/udp_tx_top.sv */
// UDP over IPv4 frame transmitter for a GMII port, top level wiring of the sub-blocks
`timescale 1ns/1ps

module udp_tx_top
    import udp_tx_pkg::*;
#(
    parameter mac_t        BOARD_MAC = 48'h00_11_22_33_44_55,
    parameter ip_addr_t    BOARD_IP  = {8'd192, 8'd168, 8'd1, 8'd123},
    parameter logic [15:0] UDP_PORT  = 16'd1234
)(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     tx_start_en,
    input  len_t     tx_byte_num,
    input  mac_t     des_mac,
    input  ip_addr_t des_ip,
    input  word_t    tx_data,
    output logic     tx_req,
    output logic     tx_done,
    output logic     gmii_tx_en,
    output byte_t    gmii_txd
);

    frame_if fr ();

    byte_t hdr_byte;
    byte_t fcs_byte;

    udp_tx_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .tx_start_en (tx_start_en),
        .tx_byte_num (tx_byte_num),
        .tx_req      (tx_req),
        .tx_done     (tx_done),
        .fr          (fr)
    );

    ip_header_gen #(
        .BOARD_MAC (BOARD_MAC),
        .BOARD_IP  (BOARD_IP),
        .UDP_PORT  (UDP_PORT)
    ) u_hdr (
        .clk         (clk),
        .rst_n       (rst_n),
        .des_mac     (des_mac),
        .des_ip      (des_ip),
        .tx_byte_num (tx_byte_num),
        .hdr_byte    (hdr_byte),
        .fr          (fr)
    );

    // CRC runs on the registered byte stream
    eth_crc32 u_crc (
        .clk      (clk),
        .rst_n    (rst_n),
        .txd      (gmii_txd),
        .fcs_byte (fcs_byte),
        .fr       (fr)
    );

    gmii_byte_mux u_mux (
        .clk        (clk),
        .rst_n      (rst_n),
        .tx_data    (tx_data),
        .hdr_byte   (hdr_byte),
        .fcs_byte   (fcs_byte),
        .gmii_tx_en (gmii_tx_en),
        .gmii_txd   (gmii_txd),
        .fr         (fr)
    );

endmodule
